/* hw/axi_rd_pkg.sv */
// AXI read master shared types
package axi_rd_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int LANES = DATA_W / 8;
	localparam int MEM_AW = 12;
	localparam int LEN_W = 4;
	localparam int ID_W = 4;
	localparam int SIZE_W = 3;
	localparam int BURST_W = 2;

	localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
	localparam logic [BURST_W-1:0] BURST_INCR = 2'd1;
	localparam logic [BURST_W-1:0] BURST_WRAP = 2'd2;

	// Request as presented by the user side
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [LEN_W-1:0] len;
		logic [SIZE_W-1:0] size;
		logic [BURST_W-1:0] burst;
	} rd_req_t;

	// AR payload, same layout as the request
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [LEN_W-1:0] len;
		logic [SIZE_W-1:0] size;
		logic [BURST_W-1:0] burst;
	} ar_chan_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic [ID_W-1:0] rid;
		logic rlast;
		logic rvalid;
	} r_chan_t;

	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [MEM_AW-1:0] wrap_base;
		logic [MEM_AW-1:0] wrap_mask;
		logic [SIZE_W-1:0] size;
		logic strobe;
	} beat_ctx_t;

	typedef struct packed {
		logic we;
		logic [MEM_AW-1:0] addr;
		logic [7:0] data;
	} lane_wr_t;

endpackage

/* hw/ar_channel.sv */
// Read address channel FSM
`timescale 1ns/1ps

module ar_channel (
	input logic clk,
	input logic resetn,
	input axi_rd_pkg::rd_req_t req,
	output axi_rd_pkg::ar_chan_t ar,
	output logic arvalid,
	input logic arready,
	input logic beat_last,
	output logic burst_active,
	output logic done
);

	import axi_rd_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_addr,
		s_data,
		s_close
	} state_t;

	state_t state;
	logic start;

	// Level start, any nonzero address while idle
	assign start = (state == s_idle) && (req.addr != '0);

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: begin
					if (start)
						state <= s_addr;
				end
				s_addr: begin
					if (arready)
						state <= s_data;
				end
				s_data: begin
					if (beat_last)
						state <= s_close;
				end
				default: begin
					state <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			ar <= ar_chan_t'(req);
	end

	assign arvalid = (state == s_addr);
	assign burst_active = (state == s_data);
	// One step after RLAST before the next request
	assign done = (state == s_close);

	ar_payload_stable: assert property (
		@(posedge clk) disable iff (!resetn)
		arvalid && !arready |=> arvalid && $stable(ar)
	);

endmodule

/* hw/beat_addr_gen.sv */
// Beat address generator
`timescale 1ns/1ps

module beat_addr_gen (
	input logic clk,
	input logic resetn,
	input logic burst_active,
	input axi_rd_pkg::ar_chan_t ar,
	input axi_rd_pkg::r_chan_t r,
	output logic rready,
	output logic beat_last,
	output axi_rd_pkg::beat_ctx_t ctx
);

	import axi_rd_pkg::*;

	logic hs;
	logic is_wrap;
	logic [MEM_AW-1:0] step;
	logic [MEM_AW-1:0] win_mask;
	logic [MEM_AW-1:0] next_addr;
	logic [MEM_AW-1:0] beat_addr;
	logic [MEM_AW-1:0] wrap_base;
	logic [MEM_AW-1:0] wrap_mask;

	// Ready through the whole data phase, no back-pressure
	assign rready = burst_active;
	assign hs = r.rvalid && rready;
	assign beat_last = hs && r.rlast;

	assign is_wrap = (ar.burst == BURST_WRAP);
	assign step = MEM_AW'(1) << ar.size;
	// Window is beats times bytes per beat, a power of two
	assign win_mask = ((MEM_AW'(ar.len) + MEM_AW'(1)) << ar.size) - MEM_AW'(1);

	always_comb begin
		case (ar.burst)
			BURST_FIXED: next_addr = beat_addr;
			BURST_INCR: next_addr = beat_addr + step;
			BURST_WRAP: next_addr = wrap_base | ((beat_addr + step) & wrap_mask);
			default: next_addr = beat_addr;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			beat_addr <= '0;
			wrap_base <= '0;
			wrap_mask <= '0;
		end else if (!burst_active) begin
			// Follow the AR payload until the data phase opens
			beat_addr <= ar.addr[MEM_AW-1:0];
			wrap_mask <= is_wrap ? win_mask : '1;
			wrap_base <= is_wrap ? (ar.addr[MEM_AW-1:0] & ~win_mask) : '0;
		end else if (hs) begin
			beat_addr <= next_addr;
		end
	end

	assign ctx.addr = beat_addr;
	assign ctx.wrap_base = wrap_base;
	assign ctx.wrap_mask = wrap_mask;
	assign ctx.size = ar.size;
	assign ctx.strobe = hs;

	size_in_range: assert property (
		@(posedge clk) disable iff (!resetn)
		burst_active |-> ar.size <= SIZE_W'(2)
	);

	wrap_len_legal: assert property (
		@(posedge clk) disable iff (!resetn)
		burst_active && is_wrap |-> ar.len inside {4'd1, 4'd3, 4'd7, 4'd15}
	);

	rid_matches: assert property (
		@(posedge clk) disable iff (!resetn)
		hs |-> r.rid == ar.id
	);

endmodule

/* hw/byte_lane.sv */
// RDATA byte lane
`timescale 1ns/1ps

module byte_lane #(
	parameter int LANE = 0,
	parameter int MEM_BYTES = 4096
) (
	input axi_rd_pkg::beat_ctx_t ctx,
	input logic [axi_rd_pkg::DATA_W-1:0] rdata,
	output axi_rd_pkg::lane_wr_t wr
);

	import axi_rd_pkg::*;

	localparam logic [MEM_AW-1:0] MEM_MASK = MEM_AW'(MEM_BYTES - 1);

	logic [MEM_AW-1:0] lin_addr;
	logic lane_used;

	assign lin_addr = ctx.addr + MEM_AW'(LANE);

	// Lanes beyond the transfer size carry no data
	assign lane_used = LANE < (32'd1 << ctx.size);

	assign wr.we = ctx.strobe && lane_used;
	// Mask is all ones outside WRAP, so this reduces to a plain offset
	assign wr.addr = (ctx.wrap_base | (lin_addr & ctx.wrap_mask)) & MEM_MASK;
	assign wr.data = rdata[8*LANE +: 8];

endmodule

/* hw/read_mem.sv */
// Local read byte memory
`timescale 1ns/1ps

module read_mem #(
	parameter int MEM_BYTES = 4096
) (
	input logic clk,
	input axi_rd_pkg::lane_wr_t [axi_rd_pkg::LANES-1:0] wr,
	input logic [axi_rd_pkg::MEM_AW-1:0] mem_raddr,
	output logic [7:0] mem_rdata
);

	import axi_rd_pkg::*;

	logic [7:0] mem [MEM_BYTES];

	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			if (wr[i].we)
				mem[wr[i].addr] <= wr[i].data;
		end
	end

	assign mem_rdata = mem[mem_raddr];

	// Lane addresses of one beat must be distinct
	for (genvar i = 0; i < LANES; i++) begin : g_chk_a
		for (genvar j = i + 1; j < LANES; j++) begin : g_chk_b
			lane_addr_unique: assert property (
				@(posedge clk)
				!(wr[i].we && wr[j].we && wr[i].addr == wr[j].addr)
			);
		end
	end

endmodule

/* hw/axi_rd_master.sv */
// AXI read master top level
`timescale 1ns/1ps

module axi_rd_master #(
	parameter int MEM_BYTES = 4096
) (
	input logic clk,
	input logic resetn,
	input axi_rd_pkg::rd_req_t req,
	output axi_rd_pkg::ar_chan_t ar,
	output logic arvalid,
	input logic arready,
	input axi_rd_pkg::r_chan_t r,
	output logic rready,
	output logic done,
	input logic [axi_rd_pkg::MEM_AW-1:0] mem_raddr,
	output logic [7:0] mem_rdata
);

	import axi_rd_pkg::*;

	logic burst_active;
	logic beat_last;
	beat_ctx_t ctx;
	lane_wr_t [LANES-1:0] lane_wr;

	ar_channel ar_channel_inst (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.beat_last(beat_last),
		.burst_active(burst_active),
		.done(done)
	);

	beat_addr_gen beat_addr_gen_inst (
		.clk(clk),
		.resetn(resetn),
		.burst_active(burst_active),
		.ar(ar),
		.r(r),
		.rready(rready),
		.beat_last(beat_last),
		.ctx(ctx)
	);

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		byte_lane #(
			.LANE(g),
			.MEM_BYTES(MEM_BYTES)
		) byte_lane_inst (
			.ctx(ctx),
			.rdata(r.rdata),
			.wr(lane_wr[g])
		);
	end

	read_mem #(
		.MEM_BYTES(MEM_BYTES)
	) read_mem_inst (
		.clk(clk),
		.wr(lane_wr),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata)
	);

endmodule

/* verif/tb_clock.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release between edges so the first active edge is clean
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

/* verif/tb_checker.sv */
// Read master checker and reference model
`timescale 1ns/1ps

module tb_checker (
	input logic clk,
	input logic resetn,
	input axi_rd_pkg::rd_req_t req,
	input axi_rd_pkg::ar_chan_t ar,
	input logic arvalid,
	input logic arready,
	input axi_rd_pkg::r_chan_t r,
	input logic rready,
	input logic done,
	input logic sweep_en,
	input logic [axi_rd_pkg::MEM_AW-1:0] mem_raddr,
	input logic [7:0] mem_rdata,
	output int error_count,
	output int done_count,
	output int check_count
);

	import axi_rd_pkg::*;

	rd_req_t cur_req;
	string test_name = "reset";
	int errors = 0;
	int dones = 0;
	int checks = 0;
	int burst_idx = 0;
	int beat_num = 0;
	logic busy = 1'b0;
	logic ar_due = 1'b0;
	logic in_data = 1'b0;
	logic done_due = 1'b0;
	logic [7:0] model_mem [4096];
	bit known [4096];

	assign error_count = errors;
	assign done_count = dones;
	assign check_count = checks;

	// Byte address of one lane of one beat by the AXI burst rules
	function automatic logic [MEM_AW-1:0] ref_byte_addr(input rd_req_t q, input int beat,
		input int lane);
		int nbytes;
		int start;
		int win;
		int base;
		int a;
		nbytes = 1 << int'(q.size);
		start = int'(q.addr[MEM_AW-1:0]);
		case (q.burst)
			BURST_FIXED: a = start + lane;
			BURST_INCR: a = start + beat * nbytes + lane;
			default: begin
				win = (int'(q.len) + 1) * nbytes;
				base = start - (start % win);
				a = base + ((start - base + beat * nbytes + lane) % win);
			end
		endcase
		return MEM_AW'(a);
	endfunction

	function automatic string burst_kind(input logic [BURST_W-1:0] b);
		case (b)
			BURST_FIXED: return "FIXED";
			BURST_INCR: return "INCR";
			default: return "WRAP";
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	always @(posedge clk) begin : watch
		int lane;
		int nbytes;
		logic [MEM_AW-1:0] a;
		if (!resetn) begin
			if (arvalid || rready || done)
				report_problem("arvalid, rready or done is high during reset");
			busy = 1'b0;
			ar_due = 1'b0;
			in_data = 1'b0;
			done_due = 1'b0;
		end else begin
			// Arvalid rises one cycle after a request seen while idle and holds until arready
			if (arvalid !== ar_due)
				report_mismatch("arvalid level", 64'(ar_due), 64'(arvalid));
			if (!busy && req.addr != '0) begin
				cur_req = req;
				test_name = $sformatf("burst %0d %s", burst_idx + 1, burst_kind(req.burst));
				busy = 1'b1;
				ar_due = 1'b1;
			end
			// Done comes exactly one cycle after the rlast edge
			if (done_due && !done)
				report_problem("no done pulse one cycle after the rlast beat");
			if (!done_due && done)
				report_problem("done pulse without a preceding rlast beat");
			if (done) begin
				dones++;
				busy = 1'b0;
			end
			done_due = 1'b0;
			if (rready !== in_data)
				report_mismatch("rready level", 64'(in_data), 64'(rready));
			if (arvalid) begin
				if (ar !== ar_chan_t'(cur_req))
					report_mismatch("AR payload", 64'(cur_req), 64'(ar));
				if (arready) begin
					ar_due = 1'b0;
					in_data = 1'b1;
					beat_num = 0;
					burst_idx++;
				end
			end
			if (r.rvalid && rready) begin
				nbytes = 1 << int'(cur_req.size);
				for (lane = 0; lane < nbytes; lane++) begin
					a = ref_byte_addr(cur_req, beat_num, lane);
					model_mem[a] = r.rdata[8*lane +: 8];
					known[a] = 1'b1;
				end
				beat_num++;
				if (r.rlast) begin
					in_data = 1'b0;
					done_due = 1'b1;
				end
			end
			// Bytes never written by any burst have no defined value
			if (sweep_en && known[mem_raddr]) begin
				checks++;
				if (mem_rdata !== model_mem[mem_raddr])
					report_mismatch($sformatf("readback at %03h", mem_raddr),
						64'(model_mem[mem_raddr]), 64'(mem_rdata));
			end
		end
	end

endmodule

/* verif/tb_top.sv */
// AXI read master testbench
`timescale 1ns/1ps

module tb_top;

	import axi_rd_pkg::*;

	localparam logic [31:0] SEED = 32'h2fbeba57;
	localparam int NUM_BURSTS = 40;
	localparam int BEAT_CYCLES = 4;
	localparam int SWEEP_CYCLES = 64;
	localparam int TIMEOUT_CYCLES = NUM_BURSTS * (16 * BEAT_CYCLES + SWEEP_CYCLES) + 500;

	logic clk;
	logic resetn;
	rd_req_t req;
	ar_chan_t ar;
	logic arvalid;
	logic arready;
	r_chan_t r;
	logic rready;
	logic done;
	logic [MEM_AW-1:0] mem_raddr;
	logic [7:0] mem_rdata;
	logic sweep_en;
	int error_count;
	int done_count;
	int check_count;
	int cycles = 0;

	tb_clock #(
		.PERIOD_NS(100),
		.RESET_CYCLES(3)
	) tb_clock_inst (
		.clk(clk),
		.resetn(resetn)
	);

	axi_rd_master #(
		.MEM_BYTES(4096)
	) axi_rd_master_inst (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rready(rready),
		.done(done),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata)
	);

	tb_checker tb_checker_inst (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.ar(ar),
		.arvalid(arvalid),
		.arready(arready),
		.r(r),
		.rready(rready),
		.done(done),
		.sweep_en(sweep_en),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata),
		.error_count(error_count),
		.done_count(done_count),
		.check_count(check_count)
	);

	task automatic pick_burst(output rd_req_t q);
		int b;
		int sz;
		int ln;
		int nbytes;
		int span;
		int a;
		b = $urandom_range(2, 0);
		sz = $urandom_range(2, 0);
		if (b == 2)
			ln = (2 << $urandom_range(3, 0)) - 1;
		else
			ln = $urandom_range(15, 0);
		nbytes = 1 << sz;
		span = (ln + 1) * nbytes;
		// Aligned, nonzero, and an INCR burst stays below 4 KB
		a = nbytes * $urandom_range((4096 - span) / nbytes, 1);
		q.addr = ADDR_W'(a);
		q.id = ID_W'($urandom_range(15, 0));
		q.len = LEN_W'(ln);
		q.size = SIZE_W'(sz);
		q.burst = BURST_W'(b);
	endtask

	// Request, then act as the slave on AR and R until done
	task automatic run_burst(input rd_req_t q);
		int delay;
		int gap;
		int beat;
		req = q;
		@(negedge clk);
		while (!arvalid) @(negedge clk);
		req.addr = '0;
		delay = $urandom_range(3, 0);
		repeat (delay) @(negedge clk);
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		for (beat = 0; beat <= int'(q.len); beat++) begin
			gap = $urandom_range(2, 0);
			repeat (gap) @(negedge clk);
			r.rvalid = 1'b1;
			r.rdata = $urandom();
			r.rid = q.id;
			r.rlast = (beat == int'(q.len));
			while (!rready) @(negedge clk);
			@(negedge clk);
			r.rvalid = 1'b0;
			r.rlast = 1'b0;
		end
		while (!done) @(negedge clk);
	endtask

	task automatic sweep_burst(input rd_req_t q);
		int nbytes;
		int span;
		int lo;
		int i;
		nbytes = 1 << int'(q.size);
		span = (int'(q.len) + 1) * nbytes;
		lo = int'(q.addr[MEM_AW-1:0]);
		// WRAP fills its whole aligned window
		if (q.burst == BURST_WRAP)
			lo = lo - (lo % span);
		sweep_en = 1'b1;
		for (i = 0; i < span; i++) begin
			mem_raddr = MEM_AW'(lo + i);
			@(negedge clk);
		end
		sweep_en = 1'b0;
	endtask

	initial begin : stimulus
		rd_req_t q;
		int n;
		req = '0;
		arready = 1'b0;
		r = '0;
		mem_raddr = '0;
		sweep_en = 1'b0;
		void'($urandom(SEED));
		wait (resetn == 1'b1);
		@(negedge clk);
		for (n = 0; n < NUM_BURSTS; n++) begin
			pick_burst(q);
			run_burst(q);
			sweep_burst(q);
		end
		repeat (2) @(negedge clk);
		if (done_count != NUM_BURSTS)
			$display("Saw %0d done pulses for %0d bursts", done_count, NUM_BURSTS);
		$display("Bursts: %0d, done pulses: %0d, readback checks: %0d, errors: %0d",
			NUM_BURSTS, done_count, check_count, error_count);
		if (error_count == 0 && done_count == NUM_BURSTS)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the bursts did not finish within %0d clock cycles",
				TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

/* compile.f */
hw/axi_rd_pkg.sv
hw/ar_channel.sv
hw/beat_addr_gen.sv
hw/byte_lane.sv
hw/read_mem.sv
hw/axi_rd_master.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI read master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f compile.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
